// ==== source/cube_cfg.svh ====
/* cube geometry and configuration register count,
   shared by the controller, registers and layer memory. */
`ifndef CUBE_CFG_SVH
`define CUBE_CFG_SVH

// layers in the cube, one per z plane.
`define CUBE_LAYERS 8

// words per layer, one word per led column position.
`define CUBE_WORDS 64

// configuration bytes following a CONF_WR command.
`define CUBE_CONF_REGS 4

`endif

// ==== source/cube_pkg.sv ====
/* command byte encoding and the packed structs passed between
   the byte receiver, the controller and the configuration registers. */
package cube_pkg;

    typedef enum logic [7:0] {
        CONF_WR = 8'h2a,  // configuration bytes follow.
        ADDR_WR = 8'h2b,  // address lane bytes follow.
        DATA_WR = 8'h2c   // colour bytes follow.
    } cube_cmd_t;

    typedef struct packed {
        logic       vld;   // one-cycle strobe.
        logic       dc;    // 0 command, 1 data.
        logic [7:0] data;
    } byte_strb_t;

    typedef struct packed {
        logic [7:0] reg3;
        logic [7:0] reg2;
        logic [7:0] reg1;
        logic [7:0] reg0;
    } cube_conf_t;

endpackage

// ==== source/spi_byte_rx.sv ====
/* serial byte receiver: pin synchronizers, serial clock edge detect,
   msb-first shift register and the one-cycle byte strobe. */
module spi_byte_rx (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 spi_sclk_i,
    input  logic                 spi_cs_n_i,
    input  logic                 spi_mosi_i,
    input  logic                 spi_dc_i,
    output cube_pkg::byte_strb_t rx_o
);
    // synchronizer bit order is {sclk, cs_n, mosi, dc}.
    logic [3:0] sync1_q;
    logic [3:0] sync2_q;
    logic       sclk_d_q;
    logic       sclk_rise;
    logic       cs_act;
    logic       bit_last;
    logic [2:0] bit_cnt_q;
    logic       last_q;
    logic       vld_q;
    logic [7:0] shift_q;
    logic       dc_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q  <= 4'b0100;  // idle link, chip select high.
            sync2_q  <= 4'b0100;
            sclk_d_q <= 1'b0;
        end else begin
            sync1_q  <= {spi_sclk_i, spi_cs_n_i, spi_mosi_i, spi_dc_i};
            sync2_q  <= sync1_q;
            sclk_d_q <= sync2_q[3];
        end
    end

    assign sclk_rise = sync2_q[3] & ~sclk_d_q;
    assign cs_act    = ~sync2_q[2];
    assign bit_last  = (bit_cnt_q == 3'd7);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt_q <= 3'd0;
            last_q    <= 1'b0;
            vld_q     <= 1'b0;
        end else begin
            if (!cs_act) begin
                bit_cnt_q <= 3'd0;  // deselect drops a partial byte.
            end else if (sclk_rise) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end
            last_q <= cs_act & sclk_rise & bit_last;
            vld_q  <= last_q;
        end
    end

    // the shift register holds still for many clocks after the 8th bit.
    always_ff @(posedge clk_i) begin
        if (cs_act && sclk_rise) begin
            shift_q <= {shift_q[6:0], sync2_q[1]};
            if (bit_last) begin
                dc_q <= sync2_q[0];  // dc taken with bit 7.
            end
        end
    end

    assign rx_o = '{vld: vld_q, dc: dc_q, data: shift_q};

    strobe_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rx_o.vld |=> !rx_o.vld);

endmodule

// ==== source/layer_ctrl.sv ====
/* command decoder and write steering for configuration bytes,
   address lane bytes and colour bytes, with the frame-done pulse. */
`include "cube_cfg.svh"

module layer_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  dc_i,
    input  logic                  byte_vld_i,
    input  logic [7:0]            byte_data_i,
    output logic [`CUBE_LAYERS:0] wr_en_o,
    output logic                  wr_done_o,
    output logic [5:0]            wr_addr_o,
    output logic [3:0]            wr_byte_en_o
);
    import cube_pkg::*;

    logic                    conf_wr_q;
    logic [`CUBE_LAYERS-1:0] layer_q;
    logic                    addr_en_q;
    logic [2:0]              lane_q;  // one-hot red, green, blue.
    logic [5:0]              addr_q;
    logic                    cmd_stb;
    logic                    data_stb;
    logic                    conf_last;
    logic                    word_last;
    logic                    blue;
    logic                    layer_last;
    logic                    frame_last;

    assign cmd_stb    = byte_vld_i & ~dc_i;
    assign data_stb   = byte_vld_i & dc_i;
    assign conf_last  = (addr_q == 6'(`CUBE_CONF_REGS - 1));
    assign word_last  = (addr_q == 6'(`CUBE_WORDS - 1));
    assign blue       = lane_q[0];
    assign layer_last = word_last & blue;
    assign frame_last = layer_last & layer_q[0];

    // bit 8 selects the registers, bits 7..0 the layers.
    assign wr_en_o      = {`CUBE_LAYERS+1{data_stb}} & {conf_wr_q, layer_q};
    assign wr_done_o    = data_stb & frame_last;
    assign wr_addr_o    = addr_q;
    assign wr_byte_en_o = {addr_en_q, lane_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            conf_wr_q <= 1'b0;
            layer_q   <= '0;
            addr_en_q <= 1'b0;
            lane_q    <= 3'b000;
            addr_q    <= 6'd0;
        end else if (cmd_stb) begin
            // every command restarts at address 0 with all targets off.
            conf_wr_q <= 1'b0;
            layer_q   <= '0;
            addr_en_q <= 1'b0;
            lane_q    <= 3'b000;
            addr_q    <= 6'd0;
            case (cube_cmd_t'(byte_data_i))
                CONF_WR: begin
                    conf_wr_q <= 1'b1;
                end
                ADDR_WR: begin
                    layer_q   <= '1;  // address lane is common to all layers.
                    addr_en_q <= 1'b1;
                end
                DATA_WR: begin
                    layer_q <= {1'b1, {`CUBE_LAYERS-1{1'b0}}};  // top layer first.
                    lane_q  <= 3'b100;
                end
                default: ;
            endcase
        end else if (data_stb) begin
            if (conf_wr_q) begin
                conf_wr_q <= ~conf_last;
                addr_q    <= addr_q + 6'd1;
            end else if (addr_en_q) begin
                addr_en_q <= ~word_last;
                if (word_last) begin
                    layer_q <= '0;
                end
                addr_q <= addr_q + 6'd1;
            end else if (|lane_q) begin
                lane_q <= frame_last ? 3'b000 : {lane_q[0], lane_q[2:1]};
                if (blue) begin
                    addr_q <= addr_q + 6'd1;  // next word after blue.
                end
                if (layer_last) begin
                    layer_q <= layer_q >> 1;
                end
            end
        end
    end

    // outside address mode a byte has one target at most.
    single_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !addr_en_q |-> $onehot0({conf_wr_q, layer_q}));

    single_lane: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(wr_byte_en_o));

endmodule

// ==== source/conf_regs.sv ====
/* four configuration byte registers, written by index,
   presented as one packed configuration word. */
`include "cube_cfg.svh"

module conf_regs (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 wr_en_i,
    input  logic [1:0]           wr_addr_i,
    input  logic [7:0]           wr_data_i,
    output cube_pkg::cube_conf_t conf_o
);
    logic [`CUBE_CONF_REGS-1:0][7:0] regs_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else if (wr_en_i) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // reg0 is the first byte after the command.
    assign conf_o = '{
        reg3: regs_q[3],
        reg2: regs_q[2],
        reg1: regs_q[1],
        reg0: regs_q[0]
    };

endmodule

// ==== source/layer_ram.sv ====
/* layer memory: eight layers of 64 words with byte-lane writes
   and a registered read port selected by layer and word. */
`include "cube_cfg.svh"

module layer_ram (
    input  logic                    clk_i,
    input  logic [`CUBE_LAYERS-1:0] wr_en_i,
    input  logic [5:0]              wr_addr_i,
    input  logic [3:0]              wr_byte_en_i,
    input  logic [7:0]              wr_data_i,
    input  logic [2:0]              rd_layer_i,
    input  logic [5:0]              rd_addr_i,
    output logic [31:0]             rd_data_o
);
    // lane 3 address, lanes 2..0 red, green, blue.
    logic [3:0][7:0] mem_q [`CUBE_LAYERS][`CUBE_WORDS];

    // one byte fans out to every enabled lane of every enabled layer.
    always_ff @(posedge clk_i) begin
        for (int l = 0; l < `CUBE_LAYERS; l++) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_en_i[l] && wr_byte_en_i[b]) begin
                    mem_q[l][wr_addr_i][b] <= wr_data_i;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rd_data_o <= mem_q[rd_layer_i][rd_addr_i];
    end

endmodule

// ==== source/cube_wr_top.sv ====
/* frame loading top level: serial byte receiver, command controller,
   configuration registers and layer memory. */
`include "cube_cfg.svh"

module cube_wr_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 spi_sclk_i,
    input  logic                 spi_cs_n_i,
    input  logic                 spi_mosi_i,
    input  logic                 spi_dc_i,
    input  logic [2:0]           rd_layer_i,
    input  logic [5:0]           rd_addr_i,
    output logic [31:0]          rd_data_o,
    output cube_pkg::cube_conf_t conf_o,
    output logic                 frame_done_o
);
    import cube_pkg::*;

    byte_strb_t            rx;
    logic [`CUBE_LAYERS:0] wr_en;
    logic [5:0]            wr_addr;
    logic [3:0]            wr_byte_en;

    spi_byte_rx u_spi_byte_rx (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .spi_sclk_i (spi_sclk_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_dc_i   (spi_dc_i),
        .rx_o       (rx)
    );

    layer_ctrl u_layer_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dc_i         (rx.dc),
        .byte_vld_i   (rx.vld),
        .byte_data_i  (rx.data),
        .wr_en_o      (wr_en),
        .wr_done_o    (frame_done_o),
        .wr_addr_o    (wr_addr),
        .wr_byte_en_o (wr_byte_en)
    );

    conf_regs u_conf_regs (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en[`CUBE_LAYERS]),
        .wr_addr_i (wr_addr[1:0]),  // low bits index the four registers.
        .wr_data_i (rx.data),
        .conf_o    (conf_o)
    );

    layer_ram u_layer_ram (
        .clk_i        (clk_i),
        .wr_en_i      (wr_en[`CUBE_LAYERS-1:0]),
        .wr_addr_i    (wr_addr),
        .wr_byte_en_i (wr_byte_en),
        .wr_data_i    (rx.data),
        .rd_layer_i   (rd_layer_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o)
    );

endmodule

// ==== verif/tb_cube_wr.sv ====
/* testbench for the cube frame loader: serial driver, lcg data,
   shadow model of memory and registers, and concurrent checks. */
`include "cube_cfg.svh"

module tb_cube_wr;
    import cube_pkg::*;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        spi_sclk_i;
    logic        spi_cs_n_i;
    logic        spi_mosi_i;
    logic        spi_dc_i;
    logic [2:0]  rd_layer_i;
    logic [5:0]  rd_addr_i;
    logic [31:0] rd_data_o;
    cube_conf_t  conf_o;
    logic        frame_done_o;

    logic [31:0] exp_mem [`CUBE_LAYERS][`CUBE_WORDS];  // shadow of the layer memory.
    cube_conf_t  exp_conf;
    logic [31:0] seed = 32'h36ba_2635;
    logic        rd_req = 1'b0;
    logic [31:0] rd_exp = '0;
    logic [31:0] rd_mask = '0;
    logic [31:0] rd_exp_d = '0;
    logic [31:0] rd_mask_d = '0;
    logic        conf_req = 1'b0;
    logic        done_allow = 1'b0;
    int          done_cnt = 0;
    int          errors = 0;
    int          failed_tests = 0;
    int          test_err_start = 0;

    cube_wr_top dut0 (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .spi_sclk_i   (spi_sclk_i),
        .spi_cs_n_i   (spi_cs_n_i),
        .spi_mosi_i   (spi_mosi_i),
        .spi_dc_i     (spi_dc_i),
        .rd_layer_i   (rd_layer_i),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o),
        .conf_o       (conf_o),
        .frame_done_o (frame_done_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        rd_exp_d  <= rd_exp;   // lines up with the registered read port.
        rd_mask_d <= rd_mask;
        if (rst_n_i && frame_done_o) begin
            done_cnt <= done_cnt + 1;
        end
    end

    mem_read_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_req |=> ((rd_data_o & rd_mask_d) === (rd_exp_d & rd_mask_d)))
        else begin
            errors++;
            $display("FAILED at %0t: rd_data_o got %h expected %h (mask %h)", $time,
                     $sampled(rd_data_o), $sampled(rd_exp_d), $sampled(rd_mask_d));
        end

    conf_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        conf_req |-> (conf_o === exp_conf))
        else begin
            errors++;
            $display("FAILED at %0t: conf_o got %h expected %h", $time,
                     $sampled(conf_o), $sampled(exp_conf));
        end

    done_only_on_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        frame_done_o |-> done_allow)
        else begin
            errors++;
            $display("FAILED at %0t: frame_done_o got 1 expected 0", $time);
        end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // msb first, 8 clocks per serial clock half period.
    task automatic send_byte(input logic dc, input logic [7:0] data);
        @(posedge clk_i);
        for (int i = 7; i >= 0; i--) begin
            spi_cs_n_i <= 1'b0;
            spi_sclk_i <= 1'b0;
            spi_mosi_i <= data[i];
            spi_dc_i   <= dc;
            repeat (8) @(posedge clk_i);
            spi_sclk_i <= 1'b1;
            repeat (8) @(posedge clk_i);
        end
        spi_sclk_i <= 1'b0;
    endtask

    task automatic end_xfer();
        @(posedge clk_i);
        spi_cs_n_i <= 1'b1;
        repeat (8) @(posedge clk_i);
    endtask

    // colour bytes land red, green, blue per word, layer 7 first.
    task automatic send_colour(input int n, input bit mark_last);
        int layer;
        int word;
        int lane;
        layer = `CUBE_LAYERS - 1;
        word  = 0;
        lane  = 2;
        for (int i = 0; i < n; i++) begin
            seed = lcg_next(seed);
            exp_mem[layer][word][lane*8 +: 8] = seed[31:24];
            if (mark_last && i == n - 1) begin
                done_allow <= 1'b1;
            end
            send_byte(1'b1, seed[31:24]);
            if (lane == 0) begin
                lane = 2;
                word++;
                if (word == `CUBE_WORDS) begin
                    word = 0;
                    layer--;
                end
            end else begin
                lane--;
            end
        end
        done_allow <= 1'b0;
    endtask

    task automatic check_memory(input logic [31:0] mask);
        @(posedge clk_i);
        for (int l = 0; l < `CUBE_LAYERS; l++) begin
            for (int w = 0; w < `CUBE_WORDS; w++) begin
                rd_layer_i <= 3'(l);
                rd_addr_i  <= 6'(w);
                rd_exp     <= exp_mem[l][w];
                rd_mask    <= mask;
                rd_req     <= 1'b1;
                @(posedge clk_i);
            end
        end
        rd_req <= 1'b0;
        repeat (2) @(posedge clk_i);
    endtask

    task automatic check_conf();
        @(posedge clk_i);
        conf_req <= 1'b1;
        @(posedge clk_i);
        conf_req <= 1'b0;
    endtask

    task automatic wait_frame_done();
        int t;
        t = 0;
        while (done_cnt == 0 && t < 2000) begin
            @(posedge clk_i);
            t++;
        end
        if (done_cnt == 0) begin
            $display("timeout: frame_done_o never pulsed after the last frame byte");
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == test_err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", num, name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    initial begin
        rst_n_i    = 1'b0;
        spi_sclk_i = 1'b0;
        spi_cs_n_i = 1'b1;
        spi_mosi_i = 1'b0;
        spi_dc_i   = 1'b0;
        rd_layer_i = 3'd0;
        rd_addr_i  = 6'd0;
        exp_conf   = '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        check_conf();
        repeat (40) @(posedge clk_i);  // quiet link, no done pulse allowed.
        finish_test(1, "reset");

        send_byte(1'b0, CONF_WR);
        for (int i = 0; i < 5; i++) begin
            seed = lcg_next(seed);
            if (i < `CUBE_CONF_REGS) begin
                exp_conf[i*8 +: 8] = seed[31:24];
            end
            send_byte(1'b1, seed[31:24]);
        end
        end_xfer();
        check_conf();
        finish_test(2, "configuration");

        send_byte(1'b0, ADDR_WR);
        for (int k = 0; k < `CUBE_WORDS; k++) begin
            for (int l = 0; l < `CUBE_LAYERS; l++) begin
                exp_mem[l][k][31:24] = 8'(k);
            end
            send_byte(1'b1, 8'(k));
        end
        end_xfer();
        check_memory(32'hff00_0000);  // colour lanes not written yet.
        finish_test(3, "address fill");

        send_byte(1'b0, DATA_WR);
        send_colour(3 * `CUBE_LAYERS * `CUBE_WORDS, 1'b1);
        wait_frame_done();
        end_xfer();
        assert (done_cnt == 1)
            else begin
                errors++;
                $display("FAILED at %0t: frame_done_o pulse count got %0d expected 1",
                         $time, done_cnt);
            end
        check_memory(32'hffff_ffff);
        finish_test(4, "full frame");

        send_byte(1'b0, DATA_WR);
        send_colour(16, 1'b0);
        send_byte(1'b0, DATA_WR);  // restart partway through the frame.
        send_colour(6, 1'b0);
        end_xfer();
        check_memory(32'hffff_ffff);
        send_byte(1'b0, 8'h55);  // arrives while colour mode is still active.
        for (int i = 0; i < 4; i++) begin
            seed = lcg_next(seed);
            send_byte(1'b1, seed[31:24]);
        end
        end_xfer();
        check_memory(32'hffff_ffff);
        finish_test(5, "unknown command and restart");

        $display("5 tests run, %0d failed, %0d errors", failed_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/cube_pkg.sv
source/spi_byte_rx.sv
source/layer_ctrl.sv
source/conf_regs.sv
source/layer_ram.sv
source/cube_wr_top.sv
verif/tb_cube_wr.sv
